/* design/lane_pkg.sv */
/*
  Shared sizes, vector types and command formats of the vector lane.
  Every lane module pulls these in with a wildcard import in its header.
*/
`default_nettype none

package lane_pkg;

  // Lane geometry
  localparam int unsigned NrBanks    = 4;
  localparam int unsigned NrVRegs    = 8;
  localparam int unsigned MaxVl      = 16;
  localparam int unsigned NrVInsn    = 4;
  localparam int unsigned NrOpQueues = 2;
  localparam int unsigned QueueDepth = 4;
  localparam int unsigned NrMasters  = 4;
  localparam int unsigned ElemWidth  = 32;

  // Derived sizes
  localparam int unsigned BankBits  = $clog2(NrBanks);
  localparam int unsigned ElemBits  = $clog2(MaxVl);
  localparam int unsigned BankDepth = NrVRegs * MaxVl / NrBanks;

  // Arbiter master slots after the two operand requesters
  localparam int unsigned MstAlu = NrOpQueues;
  localparam int unsigned MstLd  = NrOpQueues + 1;

  typedef logic [ElemWidth-1:0]                   elem_t;
  // Register number in the high bits, element index below, bank in the low 2 bits
  typedef logic [$clog2(NrVRegs * MaxVl)-1:0]     vaddr_t;
  typedef logic [$clog2(BankDepth)-1:0]           baddr_t;
  typedef logic [$clog2(NrVRegs)-1:0]             vreg_t;
  typedef logic [$clog2(MaxVl + 1)-1:0]           vlen_t;
  typedef logic [$clog2(NrVInsn)-1:0]             vid_t;
  typedef logic [$clog2(NrMasters)-1:0]           mst_idx_t;
  typedef logic [$clog2(QueueDepth)-1:0]          qptr_t;
  typedef logic [$clog2(QueueDepth + 1)-1:0]      qcnt_t;

  typedef enum logic [1:0] {
    ADD,
    SUB,
    XOR,
    AND
  } alu_op_e;

  typedef enum logic {
    OPQ_A,
    OPQ_B
  } opqueue_e;

  // Instruction as seen on the command port
  typedef struct packed {
    alu_op_e op;
    vreg_t   vd;
    vreg_t   vs1;
    vreg_t   vs2;
    vlen_t   vl;
  } vinsn_t;

  // One operand stream for a requester
  typedef struct packed {
    vid_t               id;
    vreg_t              vs;
    vlen_t              vl;
    logic [NrVInsn-1:0] hazard;
  } opreq_cmd_t;

  typedef struct packed {
    vid_t    id;
    alu_op_e op;
    vreg_t   vd;
    vlen_t   vl;
  } alu_cmd_t;

  // Bank access, tgt only matters for reads
  typedef struct packed {
    baddr_t   baddr;
    logic     wen;
    elem_t    wdata;
    opqueue_e tgt;
  } vrf_req_t;

endpackage

`default_nettype wire

/* design/lane_sequencer.sv */
/*
  Front end of the lane. Accepts instructions, hands out instruction ids,
  records each destination register and builds the read-after-write hazard
  masks. Issues one command per operand queue plus one to the ALU.
*/
`timescale 1ns/1ps
`default_nettype none

module lane_sequencer import lane_pkg::*; (
  input  logic                              clk_i,
  input  logic                              rst_ni,
  input  logic                              insn_valid_i,
  output logic                              insn_ready_o,
  input  vinsn_t                            insn_i,
  output opreq_cmd_t [NrOpQueues-1:0]       opreq_o,
  output logic       [NrOpQueues-1:0]       opreq_valid_o,
  input  logic       [NrOpQueues-1:0]       opreq_ready_i,
  output alu_cmd_t                          alu_cmd_o,
  output logic                              alu_cmd_valid_o,
  input  logic                              alu_cmd_ready_i,
  input  logic                              done_valid_i,
  input  vid_t                              done_id_i,
  output logic       [NrVInsn-1:0]          vinsn_running_o
);

  logic [NrVInsn-1:0] running_q;
  vreg_t              vd_q [NrVInsn];
  logic [NrVInsn-1:0] haz_vs1, haz_vs2;
  logic               has_free, accept;
  vid_t               free_id;

  opreq_cmd_t [NrOpQueues-1:0] opreq_q;
  logic       [NrOpQueues-1:0] opreq_valid_q;
  alu_cmd_t                    alu_cmd_q;
  logic                        alu_valid_q;

  always_comb begin
    has_free = 1'b0;
    free_id  = '0;
    // Lowest free id wins
    for (int i = NrVInsn - 1; i >= 0; i--) begin
      if (!running_q[i]) begin
        has_free = 1'b1;
        free_id  = vid_t'(i);
      end
    end
    // Running producers of either source register
    for (int i = 0; i < NrVInsn; i++) begin
      haz_vs1[i] = running_q[i] && (vd_q[i] == insn_i.vs1);
      haz_vs2[i] = running_q[i] && (vd_q[i] == insn_i.vs2);
    end
  end

  // Only take a new instruction once every downstream slot has drained
  assign insn_ready_o = has_free && !(|opreq_valid_q) && !alu_valid_q;
  assign accept       = insn_valid_i && insn_ready_o;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      running_q     <= '0;
      opreq_valid_q <= '0;
      alu_valid_q   <= 1'b0;
    end else begin
      for (int q = 0; q < NrOpQueues; q++) begin
        if (opreq_ready_i[q]) begin
          opreq_valid_q[q] <= 1'b0;
        end
      end
      if (alu_cmd_ready_i) begin
        alu_valid_q <= 1'b0;
      end
      if (done_valid_i) begin
        running_q[done_id_i] <= 1'b0;
      end
      // New id is never the one being freed, it comes from the idle set
      if (accept) begin
        running_q[free_id] <= 1'b1;
        opreq_valid_q      <= '1;
        alu_valid_q        <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      vd_q[free_id]  <= insn_i.vd;
      opreq_q[OPQ_A] <= '{id: free_id, vs: insn_i.vs1, vl: insn_i.vl, hazard: haz_vs1};
      opreq_q[OPQ_B] <= '{id: free_id, vs: insn_i.vs2, vl: insn_i.vl, hazard: haz_vs2};
      alu_cmd_q      <= '{id: free_id, op: insn_i.op, vd: insn_i.vd, vl: insn_i.vl};
    end
  end

  assign opreq_o         = opreq_q;
  assign opreq_valid_o   = opreq_valid_q;
  assign alu_cmd_o       = alu_cmd_q;
  assign alu_cmd_valid_o = alu_valid_q;
  assign vinsn_running_o = running_q;

  // ALU may only retire an instruction that this block issued
  a_done_running: assert property (@(posedge clk_i) disable iff (!rst_ni)
    done_valid_i |-> running_q[done_id_i]);

endmodule

`default_nettype wire

/* design/operand_requester.sv */
/*
  Reads vector operands element by element out of the banked VRF, one
  request engine per operand queue, and arbitrates every bank between the
  two readers, the ALU result path and the external load port.
  Readers that depend on a running instruction advance no faster than it writes.
*/
`timescale 1ns/1ps
`default_nettype none

module operand_requester import lane_pkg::*; (
  input  logic                              clk_i,
  input  logic                              rst_ni,
  input  opreq_cmd_t [NrOpQueues-1:0]       opreq_i,
  input  logic       [NrOpQueues-1:0]       opreq_valid_i,
  output logic       [NrOpQueues-1:0]       opreq_ready_o,
  input  logic       [NrVInsn-1:0]          vinsn_running_i,
  input  logic       [NrOpQueues-1:0]       queue_ready_i,
  output logic       [NrOpQueues-1:0]       operand_issued_o,
  input  logic                              alu_req_i,
  input  vid_t                              alu_id_i,
  input  vaddr_t                            alu_addr_i,
  input  elem_t                             alu_wdata_i,
  output logic                              alu_gnt_o,
  input  logic                              ld_req_i,
  input  vaddr_t                            ld_addr_i,
  input  elem_t                             ld_wdata_i,
  output logic                              ld_gnt_o,
  output logic       [NrBanks-1:0]          vrf_req_o,
  output vrf_req_t   [NrBanks-1:0]          vrf_payload_o
);

  typedef enum logic {
    IDLE,
    REQUESTING
  } req_state_e;

  // Row per master, column per bank
  logic     [NrMasters-1:0][NrBanks-1:0] mreq;
  logic     [NrMasters-1:0][NrBanks-1:0] mgnt;
  vrf_req_t [NrMasters-1:0]              mpayload;

  // Instructions that got a result into the VRF last cycle
  logic [NrVInsn-1:0] written_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      written_q <= '0;
    end else begin
      written_q <= NrVInsn'(alu_gnt_o) << alu_id_i;
    end
  end

  for (genvar q = 0; q < NrOpQueues; q++) begin : gen_requester
    req_state_e         state_q, state_d;
    vaddr_t             addr_q, addr_d;
    vlen_t              len_q, len_d;
    logic [NrVInsn-1:0] haz_q, haz_d;
    logic [NrBanks-1:0] req_b;
    logic               stall, issued_q;

    // Wait on any producer that wrote nothing last cycle
    assign stall = |(haz_q & vinsn_running_i & ~written_q);

    assign opreq_ready_o[q]    = (state_q == IDLE);
    assign operand_issued_o[q] = issued_q;
    assign mreq[q]             = req_b;
    assign mpayload[q]         = '{baddr: baddr_t'(addr_q >> BankBits), wen: 1'b0,
                                   wdata: '0, tgt: opqueue_e'(q)};

    always_comb begin
      state_d = state_q;
      addr_d  = addr_q;
      len_d   = len_q;
      // Producers that finished drop out of the mask
      haz_d   = haz_q & vinsn_running_i;
      req_b   = '0;
      case (state_q)
        IDLE: begin
          if (opreq_valid_i[q]) begin
            addr_d = vaddr_t'(opreq_i[q].vs) << ElemBits;
            len_d  = opreq_i[q].vl;
            haz_d  = opreq_i[q].hazard;
            // Zero-length operand needs no reads at all
            if (opreq_i[q].vl != '0) begin
              state_d = REQUESTING;
            end
          end
        end
        REQUESTING: begin
          req_b[addr_q[BankBits-1:0]] = queue_ready_i[q] && !stall;
          // Arbiters grant in the same cycle
          if (|mgnt[q]) begin
            addr_d = addr_q + 1'b1;
            len_d  = len_q - 1'b1;
            if (len_q == vlen_t'(1)) begin
              state_d = IDLE;
            end
          end
        end
        default: state_d = IDLE;
      endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        state_q  <= IDLE;
        addr_q   <= '0;
        len_q    <= '0;
        haz_q    <= '0;
        issued_q <= 1'b0;
      end else begin
        state_q  <= state_d;
        addr_q   <= addr_d;
        len_q    <= len_d;
        haz_q    <= haz_d;
        // Lines up with the read data leaving the VRF
        issued_q <= |mgnt[q];
      end
    end

    // Requester with no elements left to read stays off the banks
    a_idle_no_req: assert property (@(posedge clk_i) disable iff (!rst_ni)
      (len_q == '0) |-> (mreq[q] == '0));
  end

  // Writers target the bank picked by the low address bits
  assign mreq[MstAlu]     = NrBanks'(alu_req_i) << alu_addr_i[BankBits-1:0];
  assign mreq[MstLd]      = NrBanks'(ld_req_i) << ld_addr_i[BankBits-1:0];
  assign mpayload[MstAlu] = '{baddr: baddr_t'(alu_addr_i >> BankBits), wen: 1'b1,
                              wdata: alu_wdata_i, tgt: OPQ_A};
  assign mpayload[MstLd]  = '{baddr: baddr_t'(ld_addr_i >> BankBits), wen: 1'b1,
                              wdata: ld_wdata_i, tgt: OPQ_A};
  assign alu_gnt_o        = |mgnt[MstAlu];
  assign ld_gnt_o         = |mgnt[MstLd];

  for (genvar b = 0; b < NrBanks; b++) begin : gen_bank_arb
    logic [NrMasters-1:0] breq;
    mst_idx_t             ptr_q, win, cand;

    for (genvar m = 0; m < NrMasters; m++) begin : gen_master
      assign breq[m]    = mreq[m][b];
      assign mgnt[m][b] = breq[m] && (win == mst_idx_t'(m));
    end

    // Round robin, search starts at the slot after the last winner
    always_comb begin
      win  = ptr_q;
      cand = ptr_q;
      for (int k = NrMasters - 1; k >= 0; k--) begin
        cand = ptr_q + mst_idx_t'(k);
        if (breq[cand]) begin
          win = cand;
        end
      end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        ptr_q <= '0;
      end else if (|breq) begin
        ptr_q <= win + 1'b1;
      end
    end

    assign vrf_req_o[b]     = |breq;
    assign vrf_payload_o[b] = mpayload[win];
  end

  for (genvar m = 0; m < NrMasters; m++) begin : gen_gnt_check
    a_one_gnt: assert property (@(posedge clk_i) disable iff (!rst_ni)
      $onehot0(mgnt[m]));
  end

endmodule

`default_nettype wire

/* design/vrf.sv */
/*
  Banked vector register file. Each bank takes one access per cycle.
  Writes land on the clock edge, reads come back one cycle later and
  are routed to the operand queue named in the request.
*/
`timescale 1ns/1ps
`default_nettype none

module vrf import lane_pkg::*; (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic     [NrBanks-1:0]        vrf_req_i,
  input  vrf_req_t [NrBanks-1:0]        vrf_payload_i,
  output elem_t    [NrOpQueues-1:0]     rdata_o,
  output logic     [NrOpQueues-1:0]     rvalid_o
);

  elem_t                              mem_q [NrBanks][BankDepth];
  elem_t    [NrBanks-1:0]             rd_data_q;
  opqueue_e [NrBanks-1:0]             rd_tgt_q;
  logic     [NrBanks-1:0]             rd_valid_q;
  logic     [NrOpQueues-1:0][NrBanks-1:0] hit;

  always_ff @(posedge clk_i) begin
    for (int b = 0; b < NrBanks; b++) begin
      if (vrf_req_i[b] && vrf_payload_i[b].wen) begin
        mem_q[b][vrf_payload_i[b].baddr] <= vrf_payload_i[b].wdata;
      end
      rd_data_q[b] <= mem_q[b][vrf_payload_i[b].baddr];
      rd_tgt_q[b]  <= vrf_payload_i[b].tgt;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rd_valid_q <= '0;
    end else begin
      for (int b = 0; b < NrBanks; b++) begin
        rd_valid_q[b] <= vrf_req_i[b] && !vrf_payload_i[b].wen;
      end
    end
  end

  // Steer each returning bank to its queue
  always_comb begin
    rvalid_o = '0;
    rdata_o  = '0;
    for (int q = 0; q < NrOpQueues; q++) begin
      for (int b = 0; b < NrBanks; b++) begin
        hit[q][b] = rd_valid_q[b] && (rd_tgt_q[b] == opqueue_e'(q));
        if (hit[q][b]) begin
          rvalid_o[q] = 1'b1;
          rdata_o[q]  = rd_data_q[b];
        end
      end
    end
  end

  // Each requester issues at most one read per cycle
  for (genvar q = 0; q < NrOpQueues; q++) begin : gen_route_check
    a_one_bank: assert property (@(posedge clk_i) disable iff (!rst_ni)
      $onehot0(hit[q]));
  end

endmodule

`default_nettype wire

/* design/operand_queue.sv */
/*
  Operand FIFO between the VRF and the ALU. Ready towards the requester
  accounts for the read that is still on its way back from the banks,
  so a granted read always finds a free slot.
*/
`timescale 1ns/1ps
`default_nettype none

module operand_queue import lane_pkg::*; (
  input  logic  clk_i,
  input  logic  rst_ni,
  input  logic  issued_i,
  input  logic  wvalid_i,
  input  elem_t wdata_i,
  output logic  ready_o,
  output logic  valid_o,
  output elem_t data_o,
  input  logic  pop_i
);

  elem_t buf_q [QueueDepth];
  qptr_t wptr_q, rptr_q;
  qcnt_t cnt_q;
  logic  pop;

  // At most one read in flight, flagged by issued_i until it is counted
  assign ready_o = (int'(cnt_q) + int'(issued_i)) < QueueDepth;
  assign valid_o = (cnt_q != '0);
  assign data_o  = buf_q[rptr_q];
  assign pop     = pop_i && valid_o;

  always_ff @(posedge clk_i) begin
    if (wvalid_i) begin
      buf_q[wptr_q] <= wdata_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wptr_q <= '0;
      rptr_q <= '0;
      cnt_q  <= '0;
    end else begin
      // Pointers wrap on their own, depth is a power of two
      if (wvalid_i) begin
        wptr_q <= wptr_q + 1'b1;
      end
      if (pop) begin
        rptr_q <= rptr_q + 1'b1;
      end
      cnt_q <= cnt_q + qcnt_t'(wvalid_i) - qcnt_t'(pop);
    end
  end

  // Space must have been reserved when the read was granted
  a_no_overflow: assert property (@(posedge clk_i) disable iff (!rst_ni)
    wvalid_i |-> (int'(cnt_q) < QueueDepth));

endmodule

`default_nettype wire

/* design/lane_alu.sv */
/*
  Element-wise ALU. Takes one command at a time, pops both operand
  queues together and keeps one registered result that waits for its
  VRF grant. Done goes out with the grant of the last element, or right
  away for a zero-length instruction.
*/
`timescale 1ns/1ps
`default_nettype none

module lane_alu import lane_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_ni,
  input  alu_cmd_t cmd_i,
  input  logic     cmd_valid_i,
  output logic     cmd_ready_o,
  input  logic     a_valid_i,
  input  elem_t    a_i,
  output logic     a_pop_o,
  input  logic     b_valid_i,
  input  elem_t    b_i,
  output logic     b_pop_o,
  output logic     res_req_o,
  output vid_t     res_id_o,
  output vaddr_t   res_addr_o,
  output elem_t    res_wdata_o,
  input  logic     res_gnt_i,
  output logic     done_valid_o,
  output vid_t     done_id_o
);

  alu_cmd_t cmd_q;
  logic     busy_q, res_valid_q, res_last_q;
  vlen_t    pop_cnt_q;
  vaddr_t   res_addr_q;
  elem_t    res_q;
  logic     accept, fire, res_free, last_wr;

  function automatic elem_t alu_eval(alu_op_e op, elem_t a, elem_t b);
    case (op)
      ADD:     return a + b;
      SUB:     return a - b;
      XOR:     return a ^ b;
      default: return a & b;
    endcase
  endfunction

  assign cmd_ready_o = !busy_q;
  assign accept      = cmd_valid_i && !busy_q;
  // Result slot frees up in the cycle its grant arrives
  assign res_free    = !res_valid_q || res_gnt_i;
  assign fire        = busy_q && (pop_cnt_q < cmd_q.vl) && a_valid_i && b_valid_i && res_free;
  assign a_pop_o     = fire;
  assign b_pop_o     = fire;
  assign last_wr     = res_valid_q && res_gnt_i && res_last_q;

  assign done_valid_o = last_wr || (accept && (cmd_i.vl == '0));
  assign done_id_o    = busy_q ? cmd_q.id : cmd_i.id;

  assign res_req_o   = res_valid_q;
  assign res_id_o    = cmd_q.id;
  assign res_addr_o  = res_addr_q;
  assign res_wdata_o = res_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q      <= 1'b0;
      pop_cnt_q   <= '0;
      res_valid_q <= 1'b0;
    end else begin
      if (accept) begin
        busy_q    <= (cmd_i.vl != '0);
        pop_cnt_q <= '0;
      end else if (last_wr) begin
        busy_q <= 1'b0;
      end
      if (fire) begin
        pop_cnt_q   <= pop_cnt_q + 1'b1;
        res_valid_q <= 1'b1;
      end else if (res_gnt_i) begin
        res_valid_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      cmd_q <= cmd_i;
    end
    if (fire) begin
      res_q      <= alu_eval(cmd_q.op, a_i, b_i);
      res_addr_q <= {cmd_q.vd, pop_cnt_q[ElemBits-1:0]};
      res_last_q <= (pop_cnt_q == cmd_q.vl - 1'b1);
    end
  end

endmodule

`default_nettype wire

/* design/lane_top.sv */
/*
  One lane of the vector unit. Sequencer, operand requester, VRF, the
  two operand queues and the ALU, with ALU results looping back into
  the bank arbiters. Every granted ALU write shows up on the wb_ port.
*/
`timescale 1ns/1ps
`default_nettype none

module lane_top import lane_pkg::*; (
  input  logic   clk_i,
  input  logic   rst_ni,
  input  logic   insn_valid_i,
  output logic   insn_ready_o,
  input  vinsn_t insn_i,
  input  logic   ld_req_i,
  input  vaddr_t ld_addr_i,
  input  elem_t  ld_data_i,
  output logic   ld_gnt_o,
  output logic   wb_valid_o,
  output vaddr_t wb_addr_o,
  output elem_t  wb_data_o
);

  opreq_cmd_t [NrOpQueues-1:0] opreq;
  logic       [NrOpQueues-1:0] opreq_valid, opreq_ready;
  alu_cmd_t                    alu_cmd;
  logic                        alu_cmd_valid, alu_cmd_ready;
  logic                        done_valid;
  vid_t                        done_id;
  logic       [NrVInsn-1:0]    vinsn_running;

  logic       [NrOpQueues-1:0] queue_ready, operand_issued;
  logic       [NrBanks-1:0]    vrf_req;
  vrf_req_t   [NrBanks-1:0]    vrf_payload;
  elem_t      [NrOpQueues-1:0] rdata, opq_data;
  logic       [NrOpQueues-1:0] rvalid, opq_valid, opq_pop;

  logic   alu_req, alu_gnt;
  vid_t   alu_id;
  vaddr_t alu_addr;
  elem_t  alu_wdata;

  lane_sequencer i_sequencer (
    .clk_i, .rst_ni, .insn_valid_i, .insn_ready_o, .insn_i,
    .opreq_o        (opreq),
    .opreq_valid_o  (opreq_valid),
    .opreq_ready_i  (opreq_ready),
    .alu_cmd_o      (alu_cmd),
    .alu_cmd_valid_o(alu_cmd_valid),
    .alu_cmd_ready_i(alu_cmd_ready),
    .done_valid_i   (done_valid),
    .done_id_i      (done_id),
    .vinsn_running_o(vinsn_running)
  );

  operand_requester i_requester (
    .clk_i, .rst_ni, .ld_req_i, .ld_addr_i, .ld_gnt_o,
    .opreq_i         (opreq),
    .opreq_valid_i   (opreq_valid),
    .opreq_ready_o   (opreq_ready),
    .vinsn_running_i (vinsn_running),
    .queue_ready_i   (queue_ready),
    .operand_issued_o(operand_issued),
    .alu_req_i       (alu_req),
    .alu_id_i        (alu_id),
    .alu_addr_i      (alu_addr),
    .alu_wdata_i     (alu_wdata),
    .alu_gnt_o       (alu_gnt),
    .ld_wdata_i      (ld_data_i),
    .vrf_req_o       (vrf_req),
    .vrf_payload_o   (vrf_payload)
  );

  vrf i_vrf (
    .clk_i, .rst_ni,
    .vrf_req_i    (vrf_req),
    .vrf_payload_i(vrf_payload),
    .rdata_o      (rdata),
    .rvalid_o     (rvalid)
  );

  for (genvar q = 0; q < NrOpQueues; q++) begin : gen_opq
    operand_queue i_opq (
      .clk_i, .rst_ni,
      .issued_i(operand_issued[q]),
      .wvalid_i(rvalid[q]),
      .wdata_i (rdata[q]),
      .ready_o (queue_ready[q]),
      .valid_o (opq_valid[q]),
      .data_o  (opq_data[q]),
      .pop_i   (opq_pop[q])
    );
  end

  // Queue A carries vs1, queue B carries vs2
  lane_alu i_alu (
    .clk_i, .rst_ni,
    .cmd_i       (alu_cmd),
    .cmd_valid_i (alu_cmd_valid),
    .cmd_ready_o (alu_cmd_ready),
    .a_valid_i   (opq_valid[OPQ_A]),
    .a_i         (opq_data[OPQ_A]),
    .a_pop_o     (opq_pop[OPQ_A]),
    .b_valid_i   (opq_valid[OPQ_B]),
    .b_i         (opq_data[OPQ_B]),
    .b_pop_o     (opq_pop[OPQ_B]),
    .res_req_o   (alu_req),
    .res_id_o    (alu_id),
    .res_addr_o  (alu_addr),
    .res_wdata_o (alu_wdata),
    .res_gnt_i   (alu_gnt),
    .done_valid_o(done_valid),
    .done_id_o   (done_id)
  );

  assign wb_valid_o = alu_req && alu_gnt;
  assign wb_addr_o  = alu_addr;
  assign wb_data_o  = alu_wdata;

endmodule

`default_nettype wire

/* verif/tb_lane.sv */
/*
  Testbench for the vector lane. Fills the register file through the load
  port, issues vector instructions and keeps a register model in issue order.
  Concurrent assertions compare every write-back with the expected stream.
  Built and run with Verilator through the Makefile in the project root.
*/
`timescale 1ns/1ps
`default_nettype none

module tb_lane import lane_pkg::*; ();

  localparam int NrTests     = 5;
  localparam int InsnPerTest = 6;
  localparam int CycleLimit  = NrTests * InsnPerTest * int'(MaxVl) * 8;

  typedef logic [9:0] eidx_t;

  logic   clk_i = 1'b0;
  logic   rst_ni;
  logic   insn_valid_i, insn_ready_o;
  vinsn_t insn_i;
  logic   ld_req_i, ld_gnt_o;
  vaddr_t ld_addr_i;
  elem_t  ld_data_i;
  logic   wb_valid_o;
  vaddr_t wb_addr_o;
  elem_t  wb_data_o;

  // Register model, flat element address as index
  elem_t  model [NrVRegs * MaxVl];
  // Expected write-backs, pushed at issue, consumed by the DUT
  vaddr_t exp_addr_mem [1024];
  elem_t  exp_data_mem [1024];
  eidx_t  exp_rd, exp_wr;
  vaddr_t exp_addr_cur;
  elem_t  exp_data_cur;
  logic   insn_acc_q, ld_gnt_q;

  int    seed = 37;
  int    cycles = 0;
  int    check_errors = 0;
  int    unexp_errors = 0;
  int    value_errors = 0;
  int    tests_run = 0;
  int    tests_failed = 0;
  int    errors_at_start = 0;
  string test_name;

  always #2 clk_i = ~clk_i;

  lane_top dut (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .insn_valid_i(insn_valid_i),
    .insn_ready_o(insn_ready_o),
    .insn_i      (insn_i),
    .ld_req_i    (ld_req_i),
    .ld_addr_i   (ld_addr_i),
    .ld_data_i   (ld_data_i),
    .ld_gnt_o    (ld_gnt_o),
    .wb_valid_o  (wb_valid_o),
    .wb_addr_o   (wb_addr_o),
    .wb_data_o   (wb_data_o)
  );

  // Handshakes seen at the rising edge, read back on the falling edge
  always @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      exp_rd     <= '0;
      insn_acc_q <= 1'b0;
      ld_gnt_q   <= 1'b0;
    end else begin
      insn_acc_q <= insn_valid_i && insn_ready_o;
      ld_gnt_q   <= ld_req_i && ld_gnt_o;
      if (wb_valid_o) begin
        exp_rd <= exp_rd + 1'b1;
      end
    end
  end

  always_comb begin
    exp_addr_cur = exp_addr_mem[exp_rd];
    exp_data_cur = exp_data_mem[exp_rd];
  end

  a_wb_expected: assert property (@(posedge clk_i) disable iff (!rst_ni)
    wb_valid_o |-> (exp_rd < exp_wr))
    else begin
      unexp_errors++;
      $display("Unexpected write-back in %s to address %0d", test_name, $sampled(wb_addr_o));
    end

  a_wb_value: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (wb_valid_o && (exp_rd < exp_wr)) |->
      ((wb_addr_o == exp_addr_cur) && (wb_data_o == exp_data_cur)))
    else begin
      value_errors++;
      $display("Mismatch %s: expected addr %0d data %h, actual addr %0d data %h", test_name,
               $sampled(exp_addr_cur), $sampled(exp_data_cur),
               $sampled(wb_addr_o), $sampled(wb_data_o));
    end

  // Hard stop if the lane hangs
  always @(posedge clk_i) begin
    cycles <= cycles + 1;
    if (cycles == CycleLimit) begin
      $display("Timeout after %0d cycles in %s", cycles, test_name);
      $display("Something failed");
      $finish;
    end
  end

  function automatic vaddr_t elem_addr(vreg_t r, int i);
    return vaddr_t'(int'(r) * int'(MaxVl) + i);
  endfunction

  // Element result as the instruction set defines it
  function automatic elem_t apply_op(alu_op_e op, elem_t a, elem_t b);
    elem_t r;
    case (op)
      ADD:     r = a + b;
      SUB:     r = a - b;
      XOR:     r = a ^ b;
      default: r = a & b;
    endcase
    return r;
  endfunction

  function automatic int total_errors();
    return check_errors + unexp_errors + value_errors;
  endfunction

  // Called on a falling edge, returns on the falling edge after the grant
  task automatic load_elem(vreg_t r, int i, elem_t data);
    ld_req_i  = 1'b1;
    ld_addr_i = elem_addr(r, i);
    ld_data_i = data;
    do begin
      @(negedge clk_i);
    end while (!ld_gnt_q);
    model[elem_addr(r, i)] = data;
    ld_req_i = 1'b0;
  endtask

  task automatic issue(alu_op_e op, vreg_t vd, vreg_t vs1, vreg_t vs2, vlen_t vl);
    elem_t  res;
    vaddr_t da;
    insn_i       = '{op: op, vd: vd, vs1: vs1, vs2: vs2, vl: vl};
    insn_valid_i = 1'b1;
    do begin
      @(negedge clk_i);
    end while (!insn_acc_q);
    insn_valid_i = 1'b0;
    // Model moves forward in issue order
    for (int i = 0; i < int'(vl); i++) begin
      res = apply_op(op, model[elem_addr(vs1, i)], model[elem_addr(vs2, i)]);
      da  = elem_addr(vd, i);
      exp_addr_mem[exp_wr] = da;
      exp_data_mem[exp_wr] = res;
      exp_wr               = exp_wr + 1'b1;
      model[da]            = res;
    end
  endtask

  task automatic wait_drain();
    while (exp_rd < exp_wr) begin
      @(negedge clk_i);
    end
    // Room for a stray write-back to show up
    repeat (4) @(negedge clk_i);
  endtask

  task automatic begin_test(string name);
    test_name       = name;
    errors_at_start = total_errors();
  endtask

  task automatic end_test();
    int errs;
    wait_drain();
    errs = total_errors() - errors_at_start;
    tests_run++;
    if (errs == 0) begin
      $display("Test %s: pass", test_name);
    end else begin
      tests_failed++;
      $display("Test %s: FAIL with %0d errors", test_name, errs);
    end
  endtask

  initial begin
    rst_ni       = 1'b0;
    insn_valid_i = 1'b0;
    insn_i       = '0;
    ld_req_i     = 1'b0;
    ld_addr_i    = '0;
    ld_data_i    = '0;
    exp_wr       = '0;
    test_name    = "reset";
    repeat (2) @(negedge clk_i);
    rst_ni = 1'b1;
    @(negedge clk_i);

    begin_test("reset_state");
    assert (insn_ready_o) else begin
      check_errors++;
      $display("Instruction port not ready after reset");
    end
    assert (!wb_valid_o) else begin
      check_errors++;
      $display("Write-back active right after reset");
    end
    assert (!ld_gnt_o) else begin
      check_errors++;
      $display("Load grant high right after reset");
    end
    end_test();

    // Whole register file from random data, then one of each op
    begin_test("alu_ops");
    for (int r = 0; r < int'(NrVRegs); r++) begin
      for (int i = 0; i < int'(MaxVl); i++) begin
        load_elem(vreg_t'(r), i, $random(seed));
      end
    end
    issue(ADD, 3'd0, 3'd1, 3'd2, 5'd16);
    issue(SUB, 3'd3, 3'd1, 3'd2, 5'd16);
    issue(XOR, 3'd4, 3'd2, 3'd1, 5'd16);
    issue(AND, 3'd5, 3'd1, 3'd2, 5'd16);
    end_test();

    // Each instruction reads the one before, third reads both
    begin_test("hazard_chain");
    issue(ADD, 3'd6, 3'd1, 3'd2, 5'd16);
    issue(XOR, 3'd7, 3'd6, 3'd2, 5'd16);
    issue(SUB, 3'd0, 3'd7, 3'd6, 5'd16);
    end_test();

    // Loads to v5 and v6 compete with ALU writes for the same banks
    begin_test("loads_during_alu");
    issue(ADD, 3'd0, 3'd1, 3'd2, 5'd16);
    issue(SUB, 3'd3, 3'd1, 3'd2, 5'd16);
    issue(XOR, 3'd4, 3'd2, 3'd1, 5'd16);
    for (int i = 0; i < int'(MaxVl); i++) begin
      load_elem(3'd5, i, $random(seed));
      load_elem(3'd6, i, $random(seed));
    end
    issue(AND, 3'd7, 3'd5, 3'd6, 5'd16);
    end_test();

    begin_test("lengths");
    issue(ADD, 3'd0, 3'd1, 3'd2, 5'd0);
    issue(XOR, 3'd3, 3'd1, 3'd2, 5'd1);
    issue(SUB, 3'd4, 3'd2, 3'd1, 5'd5);
    issue(AND, 3'd5, 3'd1, 3'd3, 5'd16);
    issue(ADD, 3'd6, 3'd4, 3'd5, 5'd0);
    wait_drain();
    assert (insn_ready_o) else begin
      check_errors++;
      $display("Instruction port stopped accepting after %s", test_name);
    end
    end_test();

    $display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed,
             total_errors());
    if (total_errors() == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* src.f */
design/lane_pkg.sv
design/lane_sequencer.sv
design/operand_requester.sv
design/vrf.sv
design/operand_queue.sv
design/lane_alu.sv
design/lane_top.sv
verif/tb_lane.sv

/* Makefile */
# Verilator build and run of the lane testbench

SIM  := obj_dir/Vtb_lane
SRCS := $(wildcard design/*.sv verif/*.sv)

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(SIM): src.f $(SRCS)
	verilator --binary --assert -j 0 --top-module tb_lane -f src.f \
		--Mdir obj_dir -o Vtb_lane

# Log is searched for the pass line, grep sets the exit status
run: $(SIM)
	$(SIM) > sim.log 2>&1; cat sim.log
	grep -q "^Everything OK$$" sim.log

clean:
	rm -rf obj_dir sim.log
